//--- rtl/displayPkg.sv
//----------------------------------------------------------------------
// Display and sprite-sheet geometry
//----------------------------------------------------------------------

`default_nettype none

package displayPkg;

    // Sheet is 512 pixels wide, built from 32x32 tiles
    localparam int SheetWidthLog2 = 9;
    localparam int TileSizeLog2 = 5;
    localparam int TileMax = 31;

    // Frames per animation strip
    localparam int FrameCount = 7;

    typedef logic [9:0] coord_t;
    typedef logic [15:0] pos_t;
    typedef logic [9:0] frame_t;
    typedef logic [19:0] sheetAddr_t;

    typedef struct packed {
        coord_t drawX;
        coord_t drawY;
    } pixelReq_t;

    typedef struct packed {
        pos_t xPos;
        pos_t yPos;
        logic facingRight;
    } spriteState_t;

    typedef struct packed {
        pos_t xPos;
        pos_t yPos;
    } blockPos_t;

    typedef struct packed {
        frame_t floatFrame;
        frame_t walkFrame;
        frame_t stillFrame;
    } animState_t;

    // Drawing layer, highest priority first
    typedef enum logic [1:0] {
        LAYER_SPRITE,
        LAYER_BLOCK,
        LAYER_BACKGROUND
    } layer_t;

endpackage

`default_nettype wire

//--- rtl/colorPkg.sv
//----------------------------------------------------------------------
// Palette and colour types
//----------------------------------------------------------------------

`default_nettype none

package colorPkg;

    localparam int PaletteDepth = 256;

    typedef logic [7:0] paletteIndex_t;
    typedef logic [7:0] channel_t;

    // 24-bit colour, red in the top byte as stored in the palette file
    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_t;

endpackage

`default_nettype wire

//--- rtl/frameSelect.sv
//----------------------------------------------------------------------
// Animation column select
//----------------------------------------------------------------------

`default_nettype none

module frameSelect
    import displayPkg::*;
(
    input  animState_t anim,
    output frame_t     column
);

    // A counter at or above FrameCount means that animation is idle,
    // so the next one down the list gets its turn
    always_comb
    begin
        if (anim.floatFrame < FrameCount)
        begin
            column = anim.floatFrame;
        end
        else if (anim.walkFrame < FrameCount)
        begin
            column = anim.walkFrame;
        end
        else if (anim.stillFrame < FrameCount)
        begin
            column = anim.stillFrame;
        end
        else
        begin
            // Nothing animating, show the first frame
            column = '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sheetAddress.sv
//----------------------------------------------------------------------
// Sprite-sheet address pipeline
//----------------------------------------------------------------------

`default_nettype none

module sheetAddress
    import displayPkg::*;
(
    input  logic         Clk,
    input  logic         rst,
    input  logic         pixelValid,
    input  pixelReq_t    pixel,
    input  logic         spriteHit,
    input  logic         blockHit,
    input  spriteState_t sprite,
    input  blockPos_t    block,
    input  animState_t   anim,
    output logic         addrValid,
    output sheetAddr_t   addr
);

    layer_t     layer;
    frame_t     column;
    pos_t       originX;
    pos_t       originY;
    sheetAddr_t dx;
    sheetAddr_t dy;
    sheetAddr_t rowOffset;
    sheetAddr_t tileBase;
    logic       mirror;
    sheetAddr_t nextAddr;

    frameSelect u_frameSelect (
        .anim   (anim),
        .column (column)
    );

    // Layer priority
    always_comb
    begin
        if (spriteHit)
            layer = LAYER_SPRITE;
        else if (blockHit)
            layer = LAYER_BLOCK;
        else
            layer = LAYER_BACKGROUND;
    end

    //------------------------------------------------------------------
    // Offset inside the tile
    //------------------------------------------------------------------
    assign originX = (layer == LAYER_SPRITE) ? sprite.xPos : block.xPos;
    assign originY = (layer == LAYER_SPRITE) ? sprite.yPos : block.yPos;

    assign dx = sheetAddr_t'(pixel.drawX) - sheetAddr_t'(originX);
    assign dy = sheetAddr_t'(pixel.drawY) - sheetAddr_t'(originY);
    assign rowOffset = dy << SheetWidthLog2;

    // Blocks always sit in tile 0 of the sheet
    assign tileBase = (layer == LAYER_SPRITE) ? (sheetAddr_t'(column) << TileSizeLog2) : '0;

    // Block art is drawn facing left
    assign mirror = (layer == LAYER_BLOCK) || !sprite.facingRight;

    always_comb
    begin
        if (layer == LAYER_BACKGROUND)
        begin
            nextAddr = (sheetAddr_t'(pixel.drawY) << SheetWidthLog2) + sheetAddr_t'(pixel.drawX);
        end
        else if (mirror)
        begin
            nextAddr = tileBase + sheetAddr_t'(TileMax) + rowOffset - dx;
        end
        else
        begin
            nextAddr = tileBase + rowOffset + dx;
        end
    end

    //------------------------------------------------------------------
    // Output stage
    //------------------------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
            addrValid <= 1'b0;
        else
            addrValid <= pixelValid;
    end

    always_ff @(posedge Clk)
    begin
        if (pixelValid)
            addr <= nextAddr;
    end

endmodule

`default_nettype wire

//--- rtl/paletteRom.sv
//----------------------------------------------------------------------
// Palette lookup
//----------------------------------------------------------------------

`default_nettype none

module paletteRom
    import colorPkg::*;
(
    input  logic          Clk,
    input  logic          rst,
    input  logic          indexValid,
    input  paletteIndex_t index,
    output logic          rgbValid,
    output rgb_t          rgb
);

    rgb_t paletteTable [PaletteDepth];

    // Table contents come from the palette data file
    initial
    begin
        $readmemh("rtl/palette.hex", paletteTable);
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
            rgbValid <= 1'b0;
        else
            rgbValid <= indexValid;
    end

    // Colour holds between lookups
    always_ff @(posedge Clk)
    begin
        if (indexValid)
            rgb <= paletteTable[index];
    end

endmodule

`default_nettype wire

//--- rtl/colorMapper.sv
//----------------------------------------------------------------------
// VGA colour mapper top
//----------------------------------------------------------------------

`default_nettype none

module colorMapper
    import displayPkg::*;
    import colorPkg::*;
(
    input  logic          Clk,
    input  logic          rst,

    // Address path
    input  logic          pixelValid,
    input  pixelReq_t     pixel,
    input  logic          spriteHit,
    input  logic          blockHit,
    input  spriteState_t  sprite,
    input  blockPos_t     block,
    input  animState_t    anim,
    output logic          addrValid,
    output sheetAddr_t    addr,

    // Palette path
    input  logic          indexValid,
    input  paletteIndex_t index,
    output logic          rgbValid,
    output rgb_t          rgb
);

    sheetAddress u_sheetAddress (
        .Clk        (Clk),
        .rst        (rst),
        .pixelValid (pixelValid),
        .pixel      (pixel),
        .spriteHit  (spriteHit),
        .blockHit   (blockHit),
        .sprite     (sprite),
        .block      (block),
        .anim       (anim),
        .addrValid  (addrValid),
        .addr       (addr)
    );

    // Sprite RAM sits outside, between addr and index
    paletteRom u_paletteRom (
        .Clk        (Clk),
        .rst        (rst),
        .indexValid (indexValid),
        .index      (index),
        .rgbValid   (rgbValid),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

//--- verification/colorMapperTb.sv
//----------------------------------------------------------------------
// Colour mapper testbench
//----------------------------------------------------------------------

`default_nettype none

module colorMapperTb
    import displayPkg::*;
    import colorPkg::*;
();

    logic          Clk = 1'b0;
    logic          rst;
    logic          pixelValid;
    pixelReq_t     pixel;
    logic          spriteHit;
    logic          blockHit;
    spriteState_t  sprite;
    blockPos_t     block;
    animState_t    anim;
    logic          addrValid;
    sheetAddr_t    addr;
    logic          indexValid;
    paletteIndex_t index;
    logic          rgbValid;
    rgb_t          rgb;

    rgb_t        paletteRef [PaletteDepth];
    sheetAddr_t  addrQueue [$];
    int          addrDue [$];
    rgb_t        rgbQueue [$];
    int          rgbDue [$];
    int          cycleCount = 0;
    int          errorCount = 0;
    int          testStartErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int unsigned seedDummy;

    colorMapper u_colorMapper (
        .Clk        (Clk),
        .rst        (rst),
        .pixelValid (pixelValid),
        .pixel      (pixel),
        .spriteHit  (spriteHit),
        .blockHit   (blockHit),
        .sprite     (sprite),
        .block      (block),
        .anim       (anim),
        .addrValid  (addrValid),
        .addr       (addr),
        .indexValid (indexValid),
        .index      (index),
        .rgbValid   (rgbValid),
        .rgb        (rgb)
    );

    always #10 Clk = ~Clk;

    always @(posedge Clk)
        cycleCount <= cycleCount + 1;

    task automatic valueError(input string name, input logic [23:0] expected,
                              input logic [23:0] actual);
        $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic failNote(input string msg);
        $display("%0t %s", $time, msg);
        errorCount++;
    endtask

    //------------------------------------------------------------------
    // Output checks, sampled mid-cycle
    //------------------------------------------------------------------
    always @(negedge Clk)
    begin
        if (rst && cycleCount > 0)
        begin
            assert (addrValid === 1'b0 && rgbValid === 1'b0)
            else failNote("a valid output was raised during reset");
        end
        if (addrDue.size() > 0 && addrDue[0] == cycleCount)
        begin
            assert (addrValid === 1'b1) else failNote("a pixel strobe got no addrValid");
            assert (addr === addrQueue[0])
            else valueError("addr", {4'h0, addrQueue[0]}, {4'h0, addr});
            void'(addrQueue.pop_front());
            void'(addrDue.pop_front());
        end
        else
        begin
            assert (addrValid !== 1'b1) else failNote("addrValid came with no pixel strobe");
        end
        if (rgbDue.size() > 0 && rgbDue[0] == cycleCount)
        begin
            assert (rgbValid === 1'b1) else failNote("an index strobe got no rgbValid");
            assert (rgb === rgbQueue[0]) else valueError("rgb", rgbQueue[0], rgb);
            void'(rgbQueue.pop_front());
            void'(rgbDue.pop_front());
        end
        else
        begin
            assert (rgbValid !== 1'b1) else failNote("rgbValid came with no index strobe");
        end
    end

    //------------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------------
    function automatic int expectColumn(input animState_t a);
        if (a.floatFrame < FrameCount)
            return int'(a.floatFrame);
        if (a.walkFrame < FrameCount)
            return int'(a.walkFrame);
        if (a.stillFrame < FrameCount)
            return int'(a.stillFrame);
        return 0;
    endfunction

    function automatic sheetAddr_t expectAddr(input pixelReq_t p, input logic sHit,
                                              input logic bHit, input spriteState_t s,
                                              input blockPos_t b, input animState_t a);
        int dx;
        int dy;
        int result;
        dx = int'(p.drawX) - (sHit ? int'(s.xPos) : int'(b.xPos));
        dy = int'(p.drawY) - (sHit ? int'(s.yPos) : int'(b.yPos));
        if (sHit && s.facingRight)
            result = expectColumn(a) * 32 + dy * 512 + dx;
        else if (sHit)
            result = expectColumn(a) * 32 + 31 + dy * 512 - dx;
        else if (bHit)
            result = 31 + dy * 512 - dx;
        else
            result = int'(p.drawY) * 512 + int'(p.drawX);
        return sheetAddr_t'(result);
    endfunction

    //------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------
    task automatic stepCycle();
        @(posedge Clk);
        #2;
        pixelValid = 1'b0;
        indexValid = 1'b0;
    endtask

    // An idle counter sits at FrameCount or above
    function automatic frame_t pickFrame(input logic idle);
        if (!idle)
            return frame_t'($urandom % FrameCount);
        if ($urandom % 4 == 0)
            return frame_t'(FrameCount);
        return frame_t'(FrameCount + $urandom % (1024 - FrameCount));
    endfunction

    // Mode 0..2 is the first active counter, mode 3 leaves all idle
    function automatic animState_t randomAnim(input int mode);
        animState_t a;
        a.floatFrame = pickFrame(mode >= 1);
        a.walkFrame = (mode >= 1) ? pickFrame(mode >= 2) : frame_t'($urandom % 1024);
        a.stillFrame = (mode >= 2) ? pickFrame(mode >= 3) : frame_t'($urandom % 1024);
        return a;
    endfunction

    task automatic loadPixel(input logic sHit, input logic bHit, input logic facing,
                             input int mode);
        pixelReq_t    p;
        spriteState_t s;
        blockPos_t    b;
        animState_t   a;
        s.xPos = pos_t'($urandom % 600);
        s.yPos = pos_t'($urandom % 440);
        s.facingRight = facing;
        b.xPos = pos_t'($urandom % 600);
        b.yPos = pos_t'($urandom % 440);
        a = randomAnim(mode);
        p.drawX = coord_t'((sHit ? s.xPos : b.xPos) + $urandom % 32);
        p.drawY = coord_t'((sHit ? s.yPos : b.yPos) + $urandom % 32);
        if (!sHit && !bHit)
        begin
            p.drawX = coord_t'($urandom % 1024);
            p.drawY = coord_t'($urandom % 1024);
        end
        pixel = p;
        spriteHit = sHit;
        blockHit = bHit;
        sprite = s;
        block = b;
        anim = a;
        pixelValid = 1'b1;
        addrQueue.push_back(expectAddr(p, sHit, bHit, s, b, a));
        addrDue.push_back(cycleCount + 1);
    endtask

    task automatic loadIndex(input paletteIndex_t idx);
        index = idx;
        indexValid = 1'b1;
        rgbQueue.push_back(paletteRef[idx]);
        rgbDue.push_back(cycleCount + 1);
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while ((addrQueue.size() > 0 || rgbQueue.size() > 0) && waited < 10)
        begin
            @(posedge Clk);
            waited++;
        end
        if (addrQueue.size() > 0 || rgbQueue.size() > 0)
            failNote("timed out waiting for pending results");
    endtask

    task automatic finishTest(input string name);
        int errs;
        errs = errorCount - testStartErrors;
        testsRun++;
        if (errs == 0)
        begin
            $display("test %s: pass", name);
        end
        else
        begin
            testsFailed++;
            $display("test %s: FAIL with %0d errors", name, errs);
        end
        testStartErrors = errorCount;
    endtask

    initial
    begin
        seedDummy = $urandom(69150);
        $readmemh("rtl/palette.hex", paletteRef);
        rst = 1'b1;
        pixelValid = 1'b0;
        pixel = '0;
        spriteHit = 1'b0;
        blockHit = 1'b0;
        sprite = '0;
        block = '0;
        anim = '0;
        indexValid = 1'b0;
        index = '0;

        // Strobes inside reset must not produce valids
        for (int i = 0; i < 8; i++)
        begin
            @(posedge Clk);
            #2;
            pixelValid = (i == 3);
            indexValid = (i == 4);
        end
        rst = 1'b0;
        repeat (3) stepCycle();
        finishTest("reset");

        for (int i = 0; i < 24; i++)
        begin
            stepCycle();
            loadPixel(1'b0, 1'b0, 1'b1, i % 4);
        end
        stepCycle();
        waitDrain();
        finishTest("background");

        for (int mode = 0; mode < 4; mode++)
        begin
            for (int i = 0; i < 8; i++)
            begin
                stepCycle();
                loadPixel(1'b1, 1'b0, 1'b1, mode);
            end
        end
        stepCycle();
        waitDrain();
        finishTest("sprite facing right");

        // Left sprite, block alone, then both hits
        for (int i = 0; i < 30; i++)
        begin
            stepCycle();
            loadPixel(i % 3 != 1, i % 3 != 0, (i % 3 == 2) && ($urandom % 2 == 1), i % 4);
        end
        stepCycle();
        waitDrain();
        finishTest("mirroring and priority");

        stepCycle();
        loadIndex(8'd0);
        stepCycle();
        loadIndex(8'd255);
        for (int i = 0; i < 16; i++)
        begin
            stepCycle();
            loadIndex(paletteIndex_t'($urandom % 256));
        end
        stepCycle();
        waitDrain();
        finishTest("palette lookup");

        for (int i = 0; i < 24; i++)
        begin
            stepCycle();
            loadIndex(paletteIndex_t'($urandom % 256));
            loadPixel($urandom % 2 == 1, $urandom % 2 == 1, $urandom % 2 == 1, i % 4);
        end
        stepCycle();
        waitDrain();
        finishTest("paths in parallel");

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/palette.hex
// One 24-bit RRGGBB word per entry: red = index, green = ~index, blue = index
00FF00 01FE01 02FD02 03FC03 04FB04 05FA05 06F906 07F807
08F708 09F609 0AF50A 0BF40B 0CF30C 0DF20D 0EF10E 0FF00F
10EF10 11EE11 12ED12 13EC13 14EB14 15EA15 16E916 17E817
18E718 19E619 1AE51A 1BE41B 1CE31C 1DE21D 1EE11E 1FE01F
20DF20 21DE21 22DD22 23DC23 24DB24 25DA25 26D926 27D827
28D728 29D629 2AD52A 2BD42B 2CD32C 2DD22D 2ED12E 2FD02F
30CF30 31CE31 32CD32 33CC33 34CB34 35CA35 36C936 37C837
38C738 39C639 3AC53A 3BC43B 3CC33C 3DC23D 3EC13E 3FC03F
40BF40 41BE41 42BD42 43BC43 44BB44 45BA45 46B946 47B847
48B748 49B649 4AB54A 4BB44B 4CB34C 4DB24D 4EB14E 4FB04F
50AF50 51AE51 52AD52 53AC53 54AB54 55AA55 56A956 57A857
58A758 59A659 5AA55A 5BA45B 5CA35C 5DA25D 5EA15E 5FA05F
609F60 619E61 629D62 639C63 649B64 659A65 669966 679867
689768 699669 6A956A 6B946B 6C936C 6D926D 6E916E 6F906F
708F70 718E71 728D72 738C73 748B74 758A75 768976 778877
788778 798679 7A857A 7B847B 7C837C 7D827D 7E817E 7F807F
807F80 817E81 827D82 837C83 847B84 857A85 867986 877887
887788 897689 8A758A 8B748B 8C738C 8D728D 8E718E 8F708F
906F90 916E91 926D92 936C93 946B94 956A95 966996 976897
986798 996699 9A659A 9B649B 9C639C 9D629D 9E619E 9F609F
A05FA0 A15EA1 A25DA2 A35CA3 A45BA4 A55AA5 A659A6 A758A7
A857A8 A956A9 AA55AA AB54AB AC53AC AD52AD AE51AE AF50AF
B04FB0 B14EB1 B24DB2 B34CB3 B44BB4 B54AB5 B649B6 B748B7
B847B8 B946B9 BA45BA BB44BB BC43BC BD42BD BE41BE BF40BF
C03FC0 C13EC1 C23DC2 C33CC3 C43BC4 C53AC5 C639C6 C738C7
C837C8 C936C9 CA35CA CB34CB CC33CC CD32CD CE31CE CF30CF
D02FD0 D12ED1 D22DD2 D32CD3 D42BD4 D52AD5 D629D6 D728D7
D827D8 D926D9 DA25DA DB24DB DC23DC DD22DD DE21DE DF20DF
E01FE0 E11EE1 E21DE2 E31CE3 E41BE4 E51AE5 E619E6 E718E7
E817E8 E916E9 EA15EA EB14EB EC13EC ED12ED EE11EE EF10EF
F00FF0 F10EF1 F20DF2 F30CF3 F40BF4 F50AF5 F609F6 F708F7
F807F8 F906F9 FA05FA FB04FB FC03FC FD02FD FE01FE FF00FF

//--- all.f
rtl/displayPkg.sv
rtl/colorPkg.sv
rtl/frameSelect.sv
rtl/sheetAddress.sv
rtl/paletteRom.sv
rtl/colorMapper.sv
verification/colorMapperTb.sv

//--- Bender.yml
package:
  name: color_mapper

sources:
  - files:
      - rtl/displayPkg.sv
      - rtl/colorPkg.sv
      - rtl/frameSelect.sv
      - rtl/sheetAddress.sv
      - rtl/paletteRom.sv
      - rtl/colorMapper.sv
  - target: test
    files:
      - verification/colorMapperTb.sv
